// File: Bender.yml
package:
  name: uart_link

sources:
  - files:
      - hw/uart_line_pkg.sv
      - hw/link_pkg.sv
      - hw/tx_credit_buffer.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/rx_credit_sender.sv
      - hw/uart_link_top.sv
  - target: test
    files:
      - bench/uart_link_checker.sv
      - bench/uart_link_tb.sv

// File: bench/uart_link_checker.sv
module uart_link_checker
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Tx_Valid,
  input  logic            i_Tx_Credit,
  input  logic            i_Tx_Active,
  input  logic            i_Tx_Serial,
  input  logic            i_Rx_Valid,
  input  link_pkg::byte_t i_Rx_Byte,
  input  logic            i_Rx_Credit,
  input  logic            i_Rx_Frame_Err,
  input  logic            i_Rx_Overrun,
  input  logic            i_Exp_Push,
  input  link_pkg::byte_t i_Exp_Byte,
  input  int              i_Exp_Frame_Errs,
  input  int              i_Exp_Overruns,
  input  logic            i_Final,
  output int              o_Value_Errors,
  output int              o_Event_Errors
);

  link_pkg::byte_t expected_q [$];
  link_pkg::byte_t want;
  int              value_errors = 0;
  int              event_errors = 0;
  int              host_credits = link_pkg::TX_DEPTH;   // Host view of transmit credit
  int              writes = 0;
  int              credits_back = 0;
  int              rx_credits = 0;
  int              rx_valids = 0;
  int              frame_errs = 0;
  int              overruns = 0;
  logic            reset_checked = 1'b0;
  logic            final_done = 1'b0;

  assign o_Value_Errors = value_errors;
  assign o_Event_Errors = event_errors;

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    value_errors++;
  endtask

  task automatic event_fault(input string what);
    $display("At time %0t %s", $time, what);
    event_errors++;
  endtask

  always @(posedge i_Clock)
  begin
    if (reset_n)
    begin
      // Outputs still show the reset values on the first cycle out of reset
      if (!reset_checked)
      begin
        if (i_Tx_Serial !== 1'b1) value_mismatch("o_Tx_Serial", 1, i_Tx_Serial);
        if (i_Tx_Active !== 1'b0) value_mismatch("o_Tx_Active", 0, i_Tx_Active);
        if (i_Tx_Credit !== 1'b0) value_mismatch("o_Tx_Credit", 0, i_Tx_Credit);
        if (i_Rx_Valid !== 1'b0) value_mismatch("o_Rx_Valid", 0, i_Rx_Valid);
        if (i_Rx_Frame_Err !== 1'b0) value_mismatch("o_Rx_Frame_Err", 0, i_Rx_Frame_Err);
        if (i_Rx_Overrun !== 1'b0) value_mismatch("o_Rx_Overrun", 0, i_Rx_Overrun);
        reset_checked = 1'b1;
      end
      if (i_Tx_Credit)
      begin
        host_credits++;
        credits_back++;
        if (credits_back > writes)
          event_fault("o_Tx_Credit returned more credits than bytes were written");
      end
      if (i_Tx_Valid)
      begin
        if (host_credits <= 0)
          event_fault("the host wrote a byte without holding a transmit credit");
        host_credits--;
        writes++;
      end
      if (!i_Tx_Serial && !i_Tx_Active)   // Line low means a frame is going out
        value_mismatch("o_Tx_Active", 1, i_Tx_Active);
      if (i_Rx_Credit)
        rx_credits++;
      if (i_Rx_Valid)
      begin
        rx_valids++;
        if (rx_valids > rx_credits)
          event_fault("o_Rx_Valid delivered more bytes than credits were granted");
        if (expected_q.size() == 0)
          event_fault("o_Rx_Valid delivered a byte when none was expected");
        else
        begin
          want = expected_q.pop_front();
          if (i_Rx_Byte !== want)
            value_mismatch("o_Rx_Byte", want, i_Rx_Byte);
        end
      end
      if (i_Exp_Push)
        expected_q.push_back(i_Exp_Byte);
      if (i_Rx_Frame_Err)
        frame_errs++;
      if (i_Rx_Overrun)
        overruns++;
      if (i_Final && !final_done)
      begin
        final_done = 1'b1;
        if (expected_q.size() != 0)
          event_fault($sformatf("%0d expected bytes never arrived", expected_q.size()));
        if (credits_back != writes)
          value_mismatch("o_Tx_Credit pulse count", writes, credits_back);
        if (frame_errs != i_Exp_Frame_Errs)
          value_mismatch("o_Rx_Frame_Err pulse count", i_Exp_Frame_Errs, frame_errs);
        if (overruns != i_Exp_Overruns)
          value_mismatch("o_Rx_Overrun pulse count", i_Exp_Overruns, overruns);
      end
    end
  end

endmodule

// File: bench/uart_link_patterns.txt
# mode byte : L loopback with credits, W credits withheld, B stop bit forced to 0
# hex byte value, a line after W lines releases the held credits
L 3c
L a5
L 00
L ff
L 81
L 5a
W 11
W 22
W 33
W 44
W 55
W 66
L 77
B 0f
L c3
L 18
L e7
L 42

// File: bench/uart_link_tb.sv
module uart_link_tb;

  localparam int BIT_CYCLES = uart_line_pkg::CLKS_PER_BIT;
  localparam int MAX_ITEMS  = 64;

  logic            clock;
  logic            reset_n;
  logic            tx_valid;
  link_pkg::byte_t tx_byte;
  logic            tx_credit;
  logic            tx_active;
  logic            tx_serial;
  logic            rx_serial;
  logic            rx_valid;
  link_pkg::byte_t rx_byte;
  logic            rx_credit;
  logic            rx_frame_err;
  logic            rx_overrun;

  logic            banging;    // Testbench owns the receive line
  logic            bang_bit;
  logic            exp_push;
  link_pkg::byte_t exp_byte;
  logic            final_check;
  int              exp_frame_errs = 0;
  int              exp_overruns = 0;
  int              value_errors;
  int              event_errors;

  logic [7:0]      item_mode [MAX_ITEMS];
  link_pkg::byte_t item_byte [MAX_ITEMS];
  int              n_items = 0;
  logic            items_ready = 1'b0;

  int              bytes_written = 0;
  int              credits_back = 0;
  int              rx_delivered = 0;
  int              credits_given = 0;
  int              deliveries_expected = 0;
  int              held_count = 0;
  logic            withhold = 1'b0;   // Receive credits paused

  uart_link_top DUT
  (
    .i_Clock        (clock),
    .reset_n        (reset_n),
    .i_Tx_Valid     (tx_valid),
    .i_Tx_Byte      (tx_byte),
    .o_Tx_Credit    (tx_credit),
    .o_Tx_Active    (tx_active),
    .o_Tx_Serial    (tx_serial),
    .i_Rx_Serial    (rx_serial),
    .o_Rx_Valid     (rx_valid),
    .o_Rx_Byte      (rx_byte),
    .i_Rx_Credit    (rx_credit),
    .o_Rx_Frame_Err (rx_frame_err),
    .o_Rx_Overrun   (rx_overrun)
  );

  uart_link_checker u_check
  (
    .i_Clock          (clock),
    .reset_n          (reset_n),
    .i_Tx_Valid       (tx_valid),
    .i_Tx_Credit      (tx_credit),
    .i_Tx_Active      (tx_active),
    .i_Tx_Serial      (tx_serial),
    .i_Rx_Valid       (rx_valid),
    .i_Rx_Byte        (rx_byte),
    .i_Rx_Credit      (rx_credit),
    .i_Rx_Frame_Err   (rx_frame_err),
    .i_Rx_Overrun     (rx_overrun),
    .i_Exp_Push       (exp_push),
    .i_Exp_Byte       (exp_byte),
    .i_Exp_Frame_Errs (exp_frame_errs),
    .i_Exp_Overruns   (exp_overruns),
    .i_Final          (final_check),
    .o_Value_Errors   (value_errors),
    .o_Event_Errors   (event_errors)
  );

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Loopback, or the bit-banged frame
  always @(posedge clock)
    rx_serial <= banging ? bang_bit : tx_serial;

  // Host bookkeeping, sampled away from the active edge
  always @(negedge clock)
  begin
    if (tx_credit)
      credits_back++;
    if (rx_valid)
      rx_delivered++;
  end

  // Grants one receive credit per byte still owed, with random gaps
  initial
  begin
    forever
    begin
      @(posedge clock);
      rx_credit <= 1'b0;
      if (reset_n && !withhold && credits_given < deliveries_expected)
      begin
        repeat ($urandom_range(0, 5)) @(posedge clock);
        rx_credit <= 1'b1;
        credits_given++;
      end
    end
  end

  initial
  begin
    wait (items_ready);
    repeat ((n_items + 4) * 12 * BIT_CYCLES * 2) @(posedge clock);
    $display("Watchdog expired before the test sequence finished");
    $display("tests failed");
    $finish;
  end

  task automatic load_patterns();
    int          fd;
    int          code;
    int          value;
    logic [63:0] word;
    logic [639:0] rest;
    fd = $fopen("bench/uart_link_patterns.txt", "r");
    if (fd != 0)
    begin
      while ($fscanf(fd, "%s", word) == 1)
      begin
        if (word == "#")
          code = $fgets(rest, fd);   // Rest of a comment line
        else if ($fscanf(fd, "%h", value) == 1 && n_items < MAX_ITEMS)
        begin
          item_mode[n_items] = word[7:0];
          item_byte[n_items] = link_pkg::byte_t'(value);
          n_items++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Host write under transmit credit, expected byte goes to the checker alongside
  task automatic write_byte(input link_pkg::byte_t value, input logic deliver);
    @(posedge clock);
    while (bytes_written >= link_pkg::TX_DEPTH + credits_back)
      @(posedge clock);
    tx_valid <= 1'b1;
    tx_byte  <= value;
    exp_push <= deliver;
    exp_byte <= value;
    bytes_written++;
    if (deliver)
      deliveries_expected++;
    @(posedge clock);
    tx_valid <= 1'b0;
    exp_push <= 1'b0;
  endtask

  // Waits until the line is idle and every deliverable byte has come out
  task automatic settle();
    while (credits_back != bytes_written)
      @(negedge clock);
    while (tx_active)
      @(negedge clock);
    repeat (2 * BIT_CYCLES) @(negedge clock);
    while (!withhold && rx_delivered != deliveries_expected)
      @(negedge clock);
  endtask

  task automatic release_credits();
    if (withhold)
    begin
      settle();
      withhold = 1'b0;
    end
  endtask

  // Start bit, data LSB first, then a stop bit of 0
  task automatic bang_frame(input link_pkg::byte_t value);
    logic [9:0] frame;
    int         i;
    frame = {1'b0, value, 1'b0};
    @(posedge clock);
    banging <= 1'b1;
    for (i = 0; i < 10; i++)
    begin
      bang_bit <= frame[i];
      repeat (BIT_CYCLES) @(posedge clock);
    end
    bang_bit <= 1'b1;
    repeat (2 * BIT_CYCLES) @(posedge clock);
    banging <= 1'b0;
  endtask

  task automatic run_items();
    int i;
    for (i = 0; i < n_items; i++)
    begin
      case (item_mode[i])
        "W":
        begin
          if (!withhold)
          begin
            settle();   // Receive buffer starts empty
            withhold   = 1'b1;
            held_count = 0;
          end
          write_byte(item_byte[i], held_count < link_pkg::RX_DEPTH);
          if (held_count >= link_pkg::RX_DEPTH)
            exp_overruns++;
          held_count++;
        end
        "B":
        begin
          release_credits();
          settle();
          bang_frame(item_byte[i]);
          exp_frame_errs++;
        end
        default:
        begin
          release_credits();
          write_byte(item_byte[i], 1'b1);
        end
      endcase
      repeat ($urandom_range(0, 6)) @(posedge clock);
    end
    release_credits();
    settle();
  endtask

  initial
  begin
    void'($urandom(32'hf12e));
    reset_n     = 1'b0;
    tx_valid    = 1'b0;
    tx_byte     = '0;
    rx_serial   = 1'b1;
    rx_credit   = 1'b0;
    banging     = 1'b0;
    bang_bit    = 1'b1;
    exp_push    = 1'b0;
    exp_byte    = '0;
    final_check = 1'b0;
    load_patterns();
    if (n_items == 0)
    begin
      $display("No test items could be read from the pattern file");
      $display("tests failed");
      $finish;
    end
    else
    begin
      items_ready = 1'b1;
      repeat (10) @(posedge clock);
      reset_n <= 1'b1;
      run_items();
      @(posedge clock);
      final_check <= 1'b1;
      repeat (2) @(posedge clock);
      $display("Errors counted: %0d value, %0d event", value_errors, event_errors);
      if (value_errors + event_errors == 0)
        $display("all tests passed");
      else
        $display("tests failed");
      $finish;
    end
  end

endmodule

// File: flist.f
hw/uart_line_pkg.sv
hw/link_pkg.sv
hw/tx_credit_buffer.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/rx_credit_sender.sv
hw/uart_link_top.sv
bench/uart_link_checker.sv
bench/uart_link_tb.sv

// File: hw/link_pkg.sv
package link_pkg;

  localparam int BYTE_W   = 8;
  localparam int TX_DEPTH = 4;   // Transmit buffer entries
  localparam int RX_DEPTH = 4;   // Receive buffer entries

  typedef logic [BYTE_W-1:0] byte_t;

  // Receive credits granted by the host
  typedef logic [$clog2(RX_DEPTH+1)-1:0] credit_t;

  typedef logic [$clog2(TX_DEPTH)-1:0]   tx_ptr_t;
  typedef logic [$clog2(RX_DEPTH)-1:0]   rx_ptr_t;
  typedef logic [$clog2(TX_DEPTH+1)-1:0] tx_count_t;   // Fill level, 0 to TX_DEPTH
  typedef logic [$clog2(RX_DEPTH+1)-1:0] rx_count_t;   // Fill level, 0 to RX_DEPTH

endpackage

// File: hw/rx_credit_sender.sv
module rx_credit_sender
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Rx_DV,
  input  link_pkg::byte_t i_Rx_Byte,
  input  logic            i_Rx_Credit,
  output logic            o_Rx_Valid,
  output link_pkg::byte_t o_Rx_Byte,
  output logic            o_Rx_Overrun
);

  link_pkg::byte_t     mem [link_pkg::RX_DEPTH];
  link_pkg::rx_ptr_t   wr_ptr;
  link_pkg::rx_ptr_t   rd_ptr;
  link_pkg::rx_count_t count;
  link_pkg::credit_t   credits;
  logic                full;
  logic                push;
  logic                pop;

  assign full = (count == link_pkg::rx_count_t'(link_pkg::RX_DEPTH));
  assign push = i_Rx_DV && !full;
  assign pop  = (count != '0) && (credits != '0);   // Needs both an entry and a credit

  assign o_Rx_Valid = pop;
  assign o_Rx_Byte  = mem[rd_ptr];

  always_ff @(posedge i_Clock)
  begin
    if (push)
      mem[wr_ptr] <= i_Rx_Byte;
  end

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
    begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credits      <= '0;
      o_Rx_Overrun <= 1'b0;
    end
    else
    begin
      o_Rx_Overrun <= i_Rx_DV && full;   // Byte dropped
      if (push)
        wr_ptr <= (wr_ptr == link_pkg::rx_ptr_t'(link_pkg::RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == link_pkg::rx_ptr_t'(link_pkg::RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      // Credit count saturates rather than wrapping
      if (i_Rx_Credit && !pop && (credits != '1))
        credits <= credits + 1'b1;
      else if (pop && !i_Rx_Credit)
        credits <= credits - 1'b1;
    end
  end

endmodule

// File: hw/tx_credit_buffer.sv
module tx_credit_buffer
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Tx_Valid,
  input  link_pkg::byte_t i_Tx_Byte,
  input  logic            i_Tx_Done,
  output logic            o_Tx_Credit,
  output logic            o_Tx_DV,
  output link_pkg::byte_t o_Tx_Byte
);

  link_pkg::byte_t     mem [link_pkg::TX_DEPTH];
  link_pkg::tx_ptr_t   wr_ptr;
  link_pkg::tx_ptr_t   rd_ptr;
  link_pkg::tx_count_t count;
  logic                in_flight;   // A byte is with the transmitter
  logic                push;
  logic                pop;

  // Host only writes while it holds credit, the full check is a safeguard
  assign push = i_Tx_Valid && (count != link_pkg::tx_count_t'(link_pkg::TX_DEPTH));
  assign pop  = (count != '0) && !in_flight;

  assign o_Tx_DV   = pop;
  assign o_Tx_Byte = mem[rd_ptr];

  always_ff @(posedge i_Clock)
  begin
    if (push)
      mem[wr_ptr] <= i_Tx_Byte;
  end

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      in_flight   <= 1'b0;
      o_Tx_Credit <= 1'b0;
    end
    else
    begin
      o_Tx_Credit <= pop;   // One credit back per entry freed
      if (push)
        wr_ptr <= (wr_ptr == link_pkg::tx_ptr_t'(link_pkg::TX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == link_pkg::tx_ptr_t'(link_pkg::TX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      // Pop and done never meet, done only comes while in flight
      if (pop)
        in_flight <= 1'b1;
      else if (i_Tx_Done)
        in_flight <= 1'b0;
    end
  end

endmodule

// File: hw/uart_line_pkg.sv
package uart_line_pkg;

  // Kept small so frames are short in simulation
  localparam int CLKS_PER_BIT = 16;
  localparam int DATA_BITS    = 8;

  // Sample point inside a bit, counted from the bit start
  localparam int HALF_BIT     = (CLKS_PER_BIT - 1) / 2;

  localparam int CLK_COUNT_W  = $clog2(CLKS_PER_BIT);

  // Counts clocks inside one bit time
  typedef logic [CLK_COUNT_W-1:0] clk_count_t;

  // Selects one of the data bits
  typedef logic [2:0] bit_index_t;

endpackage

// File: hw/uart_link_top.sv
module uart_link_top
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Tx_Valid,
  input  link_pkg::byte_t i_Tx_Byte,
  output logic            o_Tx_Credit,
  output logic            o_Tx_Active,
  output logic            o_Tx_Serial,
  input  logic            i_Rx_Serial,
  output logic            o_Rx_Valid,
  output link_pkg::byte_t o_Rx_Byte,
  input  logic            i_Rx_Credit,
  output logic            o_Rx_Frame_Err,
  output logic            o_Rx_Overrun
);

  logic            tx_dv;
  link_pkg::byte_t tx_byte;
  logic            tx_done;
  logic            rx_dv;
  link_pkg::byte_t rx_byte;

  // Host writes queue here until the transmitter is free
  tx_credit_buffer u_tx_buf
  (
    .i_Clock     (i_Clock),
    .reset_n     (reset_n),
    .i_Tx_Valid  (i_Tx_Valid),
    .i_Tx_Byte   (i_Tx_Byte),
    .i_Tx_Done   (tx_done),
    .o_Tx_Credit (o_Tx_Credit),
    .o_Tx_DV     (tx_dv),
    .o_Tx_Byte   (tx_byte)
  );

  uart_tx u_tx
  (
    .i_Clock     (i_Clock),
    .reset_n     (reset_n),
    .i_Tx_DV     (tx_dv),
    .i_Tx_Byte   (tx_byte),
    .o_Tx_Active (o_Tx_Active),
    .o_Tx_Serial (o_Tx_Serial),
    .o_Tx_Done   (tx_done)
  );

  uart_rx u_rx
  (
    .i_Clock        (i_Clock),
    .reset_n        (reset_n),
    .i_Rx_Serial    (i_Rx_Serial),
    .o_Rx_DV        (rx_dv),
    .o_Rx_Byte      (rx_byte),
    .o_Rx_Frame_Err (o_Rx_Frame_Err)
  );

  rx_credit_sender u_rx_send
  (
    .i_Clock      (i_Clock),
    .reset_n      (reset_n),
    .i_Rx_DV      (rx_dv),
    .i_Rx_Byte    (rx_byte),
    .i_Rx_Credit  (i_Rx_Credit),
    .o_Rx_Valid   (o_Rx_Valid),
    .o_Rx_Byte    (o_Rx_Byte),
    .o_Rx_Overrun (o_Rx_Overrun)
  );

endmodule

// File: hw/uart_rx.sv
module uart_rx
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Rx_Serial,
  output logic            o_Rx_DV,
  output link_pkg::byte_t o_Rx_Byte,
  output logic            o_Rx_Frame_Err
);

  typedef enum logic [2:0] {
    s_idle,
    s_start_bit,
    s_data_bits,
    s_stop_bit,
    s_cleanup
  } rx_state_t;

  rx_state_t                 state_cs;
  rx_state_t                 state_ns;
  uart_line_pkg::clk_count_t clock_count;
  uart_line_pkg::bit_index_t bit_index;
  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      bit_end;
  logic                      half_end;
  logic                      last_bit;

  assign bit_end  = (clock_count == uart_line_pkg::clk_count_t'(uart_line_pkg::CLKS_PER_BIT - 1));
  assign half_end = (clock_count == uart_line_pkg::clk_count_t'(uart_line_pkg::HALF_BIT));
  assign last_bit = (bit_index == uart_line_pkg::bit_index_t'(uart_line_pkg::DATA_BITS - 1));

  // Two flop synchronizer plus one more stage for edge detect
  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= i_Rx_Serial;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
      state_cs <= s_idle;
    else
      state_cs <= state_ns;
  end

  always_comb
  begin
    state_ns = state_cs;
    case (state_cs)
      s_idle:      if (rx_prev && !rx_sync) state_ns = s_start_bit;
      s_start_bit: if (half_end) state_ns = rx_sync ? s_idle : s_data_bits;   // False start
      s_data_bits: if (bit_end && last_bit) state_ns = s_stop_bit;
      s_stop_bit:  if (bit_end) state_ns = s_cleanup;
      default:     state_ns = s_idle;
    endcase
  end

  // Each data bit lands in its own position, LSB first
  always_ff @(posedge i_Clock)
  begin
    if (state_cs == s_data_bits && bit_end)
      o_Rx_Byte[bit_index] <= rx_sync;
  end

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
    begin
      o_Rx_DV        <= 1'b0;
      o_Rx_Frame_Err <= 1'b0;
      clock_count    <= '0;
      bit_index      <= '0;
    end
    else
    begin
      o_Rx_DV        <= 1'b0;
      o_Rx_Frame_Err <= 1'b0;
      case (state_cs)
        s_start_bit:
          clock_count <= half_end ? '0 : clock_count + 1'b1;   // Now aligned to bit middle
        s_data_bits:
        begin
          clock_count <= bit_end ? '0 : clock_count + 1'b1;
          if (bit_end)
            bit_index <= last_bit ? '0 : bit_index + 1'b1;
        end
        s_stop_bit:
        begin
          clock_count <= bit_end ? '0 : clock_count + 1'b1;
          if (bit_end)
          begin
            o_Rx_DV        <= rx_sync;
            o_Rx_Frame_Err <= !rx_sync;   // Stop bit read as 0
          end
        end
        default:
        begin
          clock_count <= '0;
          bit_index   <= '0;
        end
      endcase
    end
  end

endmodule

// File: hw/uart_tx.sv
module uart_tx
(
  input  logic            i_Clock,
  input  logic            reset_n,
  input  logic            i_Tx_DV,
  input  link_pkg::byte_t i_Tx_Byte,
  output logic            o_Tx_Active,
  output logic            o_Tx_Serial,
  output logic            o_Tx_Done
);

  typedef enum logic [2:0] {
    s_idle,
    s_start_bit,
    s_data_bits,
    s_stop_bit,
    s_cleanup
  } tx_state_t;

  tx_state_t                 state_cs;
  tx_state_t                 state_ns;
  uart_line_pkg::clk_count_t clock_count;
  uart_line_pkg::bit_index_t bit_index;
  link_pkg::byte_t           tx_data;
  logic                      bit_end;
  logic                      last_bit;

  assign bit_end  = (clock_count == uart_line_pkg::clk_count_t'(uart_line_pkg::CLKS_PER_BIT - 1));
  assign last_bit = (bit_index == uart_line_pkg::bit_index_t'(uart_line_pkg::DATA_BITS - 1));

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
      state_cs <= s_idle;
    else
      state_cs <= state_ns;
  end

  always_comb
  begin
    state_ns = state_cs;
    case (state_cs)
      s_idle:      if (i_Tx_DV) state_ns = s_start_bit;
      s_start_bit: if (bit_end) state_ns = s_data_bits;
      s_data_bits: if (bit_end && last_bit) state_ns = s_stop_bit;
      s_stop_bit:  if (bit_end) state_ns = s_cleanup;
      default:     state_ns = s_idle;   // Cleanup lasts one clock
    endcase
  end

  // Byte is captured once per frame
  always_ff @(posedge i_Clock)
  begin
    if (state_cs == s_idle && i_Tx_DV)
      tx_data <= i_Tx_Byte;
  end

  always_ff @(posedge i_Clock)
  begin
    if (!reset_n)
    begin
      o_Tx_Serial <= 1'b1;   // Line idles high
      o_Tx_Active <= 1'b0;
      o_Tx_Done   <= 1'b0;
      clock_count <= '0;
      bit_index   <= '0;
    end
    else
    begin
      o_Tx_Done <= 1'b0;
      case (state_cs)
        s_idle:
        begin
          o_Tx_Serial <= 1'b1;
          clock_count <= '0;
          bit_index   <= '0;
          if (i_Tx_DV)
            o_Tx_Active <= 1'b1;
        end
        s_start_bit:
        begin
          o_Tx_Serial <= 1'b0;
          clock_count <= bit_end ? '0 : clock_count + 1'b1;
        end
        s_data_bits:
        begin
          o_Tx_Serial <= tx_data[bit_index];   // LSB first
          clock_count <= bit_end ? '0 : clock_count + 1'b1;
          if (bit_end)
            bit_index <= last_bit ? '0 : bit_index + 1'b1;
        end
        s_stop_bit:
        begin
          o_Tx_Serial <= 1'b1;
          clock_count <= bit_end ? '0 : clock_count + 1'b1;
          if (bit_end)
          begin
            o_Tx_Done   <= 1'b1;   // High for the cleanup clock only
            o_Tx_Active <= 1'b0;
          end
        end
        default:
          clock_count <= '0;
      endcase
    end
  end

endmodule
